//--- Makefile
VERILATOR := verilator
TOP       := rhythm_core_tb
FILELIST  := rhythm_core.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)
LOG       := sim.log

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))
DATA := verification/rhythm_tests.dat

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: $(SIM) $(DATA)
	./$(SIM) | tee $(LOG)
	grep -q '\*\*\* TEST PASSED \*\*\*' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- hw/block_sequencer.sv
`timescale 1ns/1ps

module block_sequencer import rhythm_pkg::*; #(
    parameter int MAX_BLOCKS  = 8,
    parameter int TICK_CYCLES = 16,
    localparam int SLOT_W = (MAX_BLOCKS > 1) ? $clog2(MAX_BLOCKS) : 1
) (
    input  logic              clk_in,
    input  logic              rst_in,
    input  logic              start,
    input  logic              map_wr,
    input  logic [SLOT_W-1:0] map_slot,
    input  game_time_t        map_time,
    input  coord_t            map_x,
    input  coord_t            map_y,
    input  swing_dir_t        map_dir,
    input  game_state_t       game_state,
    input  logic              hit,
    input  logic              miss,
    input  logic [SLOT_W-1:0] judged_slot,
    output logic              tick,
    output game_time_t        curr_time,
    output logic              dec_valid,
    output logic [SLOT_W-1:0] dec_slot,
    output game_time_t        dec_time,
    output coord_t            dec_x,
    output coord_t            dec_y,
    output swing_dir_t        dec_dir,
    output logic              all_resolved
);

    localparam int CNT_W = $clog2(TICK_CYCLES);

    // Beatmap storage
    game_time_t mem_time [MAX_BLOCKS];
    coord_t     mem_x    [MAX_BLOCKS];
    coord_t     mem_y    [MAX_BLOCKS];
    swing_dir_t mem_dir  [MAX_BLOCKS];

    logic [MAX_BLOCKS-1:0] resolved;
    logic [MAX_BLOCKS-1:0] slot_used;
    logic [CNT_W-1:0]      cycle_cnt;
    logic [SLOT_W-1:0]     scan_slot;
    logic                  playing;
    logic                  scan_en;
    logic                  map_wr_ok;

    assign playing   = (game_state == ST_PLAYING);
    assign map_wr_ok = map_wr && (game_state == ST_IDLE);

    // Last cycle of each tick period
    assign tick = playing && (cycle_cnt == CNT_W'(TICK_CYCLES - 1));

    // Slots are read one per cycle at the start of the period
    assign scan_en   = playing && (cycle_cnt < CNT_W'(MAX_BLOCKS));
    assign scan_slot = cycle_cnt[SLOT_W-1:0];

    //////////////////////////////
    // Tick and game time
    //////////////////////////////

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            cycle_cnt <= '0;
            curr_time <= '0;
        end else if (start) begin
            cycle_cnt <= '0;
            curr_time <= '0;
        end else if (playing) begin
            if (tick) begin
                cycle_cnt <= '0;
                curr_time <= curr_time + 18'd1;
            end else begin
                cycle_cnt <= cycle_cnt + CNT_W'(1);
            end
        end
    end

    //////////////////////////////
    // Beatmap writes
    //////////////////////////////

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            for (int i = 0; i < MAX_BLOCKS; i++) begin
                mem_dir[i] <= DIR_NONE;
            end
        end else if (map_wr_ok) begin
            mem_dir[map_slot] <= map_dir;
        end
    end

    always_ff @(posedge clk_in) begin
        if (map_wr_ok) begin
            mem_time[map_slot] <= map_time;
            mem_x[map_slot]    <= map_x;
            mem_y[map_slot]    <= map_y;
        end
    end

    // One flag per slot, set when the judge reports it
    always_ff @(posedge clk_in) begin
        if (rst_in || start) begin
            resolved <= '0;
        end else begin
            if (map_wr_ok) begin
                resolved[map_slot] <= 1'b0;
            end
            if (hit || miss) begin
                resolved[judged_slot] <= 1'b1;
            end
        end
    end

    //////////////////////////////
    // Decode stage
    //////////////////////////////

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= scan_en && (mem_dir[scan_slot] != DIR_NONE) && !resolved[scan_slot];
        end
    end

    always_ff @(posedge clk_in) begin
        dec_slot <= scan_slot;
        dec_time <= mem_time[scan_slot];
        dec_x    <= mem_x[scan_slot];
        dec_y    <= mem_y[scan_slot];
        dec_dir  <= mem_dir[scan_slot];
    end

    always_comb begin
        for (int i = 0; i < MAX_BLOCKS; i++) begin
            slot_used[i] = (mem_dir[i] != DIR_NONE);
        end
    end

    // Empty map never counts as cleared
    assign all_resolved = (|slot_used) && ((slot_used & ~resolved) == '0);

endmodule

//--- hw/rhythm_core.sv
`timescale 1ns/1ps

module rhythm_core import rhythm_pkg::*; #(
    parameter int MAX_BLOCKS  = 8,
    parameter int TICK_CYCLES = 16,
    parameter int HIT_WINDOW  = 2,
    parameter int HIT_RADIUS  = 64,
    parameter int SWING_MIN   = 32,
    localparam int SLOT_W = (MAX_BLOCKS > 1) ? $clog2(MAX_BLOCKS) : 1
) (
    input  logic              clk_in,
    input  logic              rst_in,
    input  logic              start,
    input  coord_t            hand_x,
    input  coord_t            hand_y,
    input  logic              map_wr,
    input  logic [SLOT_W-1:0] map_slot,
    input  game_time_t        map_time,
    input  coord_t            map_x,
    input  coord_t            map_y,
    input  swing_dir_t        map_dir,
    output game_state_t       game_state,
    output score_t            score,
    output health_t           health,
    output combo_t            combo,
    output game_time_t        curr_time,
    output logic              hit,
    output logic              miss
);

    //////////////////////////////
    // Internal nets
    //////////////////////////////

    logic              tick;
    logic              dec_valid;
    logic [SLOT_W-1:0] dec_slot;
    game_time_t        dec_time;
    coord_t            dec_x;
    coord_t            dec_y;
    swing_dir_t        dec_dir;
    swing_dir_t        swing_dir;
    logic [SLOT_W-1:0] judged_slot;
    logic              all_resolved;

    // Decode stage
    block_sequencer #(
        .MAX_BLOCKS  (MAX_BLOCKS),
        .TICK_CYCLES (TICK_CYCLES)
    ) u_block_sequencer (
        .clk_in       (clk_in),
        .rst_in       (rst_in),
        .start        (start),
        .map_wr       (map_wr),
        .map_slot     (map_slot),
        .map_time     (map_time),
        .map_x        (map_x),
        .map_y        (map_y),
        .map_dir      (map_dir),
        .game_state   (game_state),
        .hit          (hit),
        .miss         (miss),
        .judged_slot  (judged_slot),
        .tick         (tick),
        .curr_time    (curr_time),
        .dec_valid    (dec_valid),
        .dec_slot     (dec_slot),
        .dec_time     (dec_time),
        .dec_x        (dec_x),
        .dec_y        (dec_y),
        .dec_dir      (dec_dir),
        .all_resolved (all_resolved)
    );

    saber_tracker #(
        .SWING_MIN (SWING_MIN)
    ) u_saber_tracker (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .start     (start),
        .tick      (tick),
        .hand_x    (hand_x),
        .hand_y    (hand_y),
        .swing_dir (swing_dir)
    );

    // Execute stage
    slice_judge #(
        .MAX_BLOCKS (MAX_BLOCKS),
        .HIT_WINDOW (HIT_WINDOW),
        .HIT_RADIUS (HIT_RADIUS)
    ) u_slice_judge (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .dec_valid   (dec_valid),
        .dec_slot    (dec_slot),
        .dec_time    (dec_time),
        .dec_x       (dec_x),
        .dec_y       (dec_y),
        .dec_dir     (dec_dir),
        .curr_time   (curr_time),
        .swing_dir   (swing_dir),
        .hand_x      (hand_x),
        .hand_y      (hand_y),
        .hit         (hit),
        .miss        (miss),
        .judged_slot (judged_slot)
    );

    // Result stage
    score_keeper u_score_keeper (
        .clk_in       (clk_in),
        .rst_in       (rst_in),
        .start        (start),
        .hit          (hit),
        .miss         (miss),
        .all_resolved (all_resolved),
        .game_state   (game_state),
        .score        (score),
        .health       (health),
        .combo        (combo)
    );

endmodule

//--- hw/rhythm_pkg.sv
package rhythm_pkg;

    //////////////////////////////
    // Widths
    //////////////////////////////

    // Screen coordinate of a saber tip or block
    typedef logic [11:0] coord_t;

    // Game time in ticks
    typedef logic [17:0] game_time_t;

    typedef logic [11:0] score_t;
    typedef logic [3:0]  health_t;
    typedef logic [2:0]  combo_t;

    //////////////////////////////
    // Enums
    //////////////////////////////

    // DIR_NONE in a beatmap slot means the slot is empty
    typedef enum logic [2:0] {
        DIR_NONE  = 3'd0,
        DIR_UP    = 3'd1,
        DIR_DOWN  = 3'd2,
        DIR_LEFT  = 3'd3,
        DIR_RIGHT = 3'd4
    } swing_dir_t;

    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,
        ST_PLAYING = 2'd1,
        ST_WON     = 2'd2,
        ST_LOST    = 2'd3
    } game_state_t;

    // Game constants
    localparam health_t HEALTH_START = 4'd4;
    localparam combo_t  COMBO_MAX    = 3'd4;

    // Absolute distance between two coordinates on one axis
    function automatic coord_t coord_dist(input coord_t a, input coord_t b);
        coord_t d;
        d = (a > b) ? (a - b) : (b - a);
        return d;
    endfunction

endpackage

//--- hw/saber_tracker.sv
`timescale 1ns/1ps

module saber_tracker import rhythm_pkg::*; #(
    parameter int SWING_MIN = 32
) (
    input  logic       clk_in,
    input  logic       rst_in,
    input  logic       start,
    input  logic       tick,
    input  coord_t     hand_x,
    input  coord_t     hand_y,
    output swing_dir_t swing_dir
);

    localparam coord_t MIN_MOVE = coord_t'(SWING_MIN);

    // Sample from the previous tick, or from start
    coord_t     prev_x;
    coord_t     prev_y;
    coord_t     dist_x;
    coord_t     dist_y;
    swing_dir_t dir_next;

    assign dist_x = coord_dist(hand_x, prev_x);
    assign dist_y = coord_dist(hand_y, prev_y);

    // Dominant axis decides, x wins a tie
    always_comb begin
        dir_next = DIR_NONE;
        if (dist_x >= dist_y) begin
            if (dist_x >= MIN_MOVE) begin
                dir_next = (hand_x > prev_x) ? DIR_RIGHT : DIR_LEFT;
            end
        end else begin
            if (dist_y >= MIN_MOVE) begin
                // Screen y grows downward
                dir_next = (hand_y > prev_y) ? DIR_DOWN : DIR_UP;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            swing_dir <= DIR_NONE;
        end else if (start) begin
            swing_dir <= DIR_NONE;
        end else if (tick) begin
            swing_dir <= dir_next;
        end
    end

    always_ff @(posedge clk_in) begin
        if (start || tick) begin
            prev_x <= hand_x;
            prev_y <= hand_y;
        end
    end

endmodule

//--- hw/score_keeper.sv
`timescale 1ns/1ps

module score_keeper import rhythm_pkg::*; (
    input  logic        clk_in,
    input  logic        rst_in,
    input  logic        start,
    input  logic        hit,
    input  logic        miss,
    input  logic        all_resolved,
    output game_state_t game_state,
    output score_t      score,
    output health_t     health,
    output combo_t      combo
);

    combo_t combo_inc;
    logic   last_life;

    // Combo after a hit, held at the ceiling
    assign combo_inc = (combo == COMBO_MAX) ? COMBO_MAX : combo + 3'd1;
    assign last_life = (health == health_t'(1));

    //////////////////////////////
    // Game FSM
    //////////////////////////////

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            game_state <= ST_IDLE;
            score      <= '0;
            combo      <= '0;
            health     <= HEALTH_START;
        end else if (start) begin
            // Restart is allowed from any state
            game_state <= ST_PLAYING;
            score      <= '0;
            combo      <= '0;
            health     <= HEALTH_START;
        end else begin
            case (game_state)
                ST_PLAYING: begin
                    if (hit) begin
                        combo <= combo_inc;
                        score <= score + score_t'(combo_inc);
                    end
                    if (miss) begin
                        combo  <= '0;
                        health <= health - 4'd1;
                    end

                    // Running out of health beats clearing the map
                    if (miss && last_life) begin
                        game_state <= ST_LOST;
                    end else if (all_resolved) begin
                        game_state <= ST_WON;
                    end
                end

                // Idle and ended games wait for start
                default: begin
                    game_state <= game_state;
                end
            endcase
        end
    end

endmodule

//--- hw/slice_judge.sv
`timescale 1ns/1ps

module slice_judge import rhythm_pkg::*; #(
    parameter int MAX_BLOCKS = 8,
    parameter int HIT_WINDOW = 2,
    parameter int HIT_RADIUS = 64,
    localparam int SLOT_W = (MAX_BLOCKS > 1) ? $clog2(MAX_BLOCKS) : 1
) (
    input  logic              clk_in,
    input  logic              rst_in,
    input  logic              dec_valid,
    input  logic [SLOT_W-1:0] dec_slot,
    input  game_time_t        dec_time,
    input  coord_t            dec_x,
    input  coord_t            dec_y,
    input  swing_dir_t        dec_dir,
    input  game_time_t        curr_time,
    input  swing_dir_t        swing_dir,
    input  coord_t            hand_x,
    input  coord_t            hand_y,
    output logic              hit,
    output logic              miss,
    output logic [SLOT_W-1:0] judged_slot
);

    localparam logic signed [18:0] WINDOW = 19'(HIT_WINDOW);
    localparam coord_t             RADIUS = coord_t'(HIT_RADIUS);

    coord_t     hand_q_x;
    coord_t     hand_q_y;
    coord_t     samp_x;
    coord_t     samp_y;
    game_time_t time_q;

    logic signed [18:0] late;
    logic               in_window;
    logic               dir_ok;
    logic               near;
    logic               hit_now;
    logic               miss_now;

    //////////////////////////////
    // Hand sample at the tick
    //////////////////////////////

    // hand_q holds the value seen at the last edge, so when curr_time
    // has just moved it is the tracker's tick sample
    always_ff @(posedge clk_in) begin
        hand_q_x <= hand_x;
        hand_q_y <= hand_y;
        if (curr_time != time_q) begin
            samp_x <= hand_q_x;
            samp_y <= hand_q_y;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            time_q <= '0;
        end else begin
            time_q <= curr_time;
        end
    end

    //////////////////////////////
    // Judgment
    //////////////////////////////

    // Positive when the block is overdue
    assign late      = $signed({1'b0, curr_time}) - $signed({1'b0, dec_time});
    assign in_window = (late <= WINDOW) && (late >= -WINDOW);
    assign dir_ok    = (swing_dir == dec_dir);
    assign near      = (coord_dist(samp_x, dec_x) <= RADIUS) &&
                       (coord_dist(samp_y, dec_y) <= RADIUS);

    assign hit_now  = dec_valid && in_window && dir_ok && near;
    assign miss_now = dec_valid && !hit_now && (late > WINDOW);

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            hit  <= 1'b0;
            miss <= 1'b0;
        end else begin
            hit  <= hit_now;
            miss <= miss_now;
        end
    end

    always_ff @(posedge clk_in) begin
        judged_slot <= dec_slot;
    end

endmodule

//--- rhythm_core.f
hw/rhythm_pkg.sv
hw/block_sequencer.sv
hw/saber_tracker.sv
hw/slice_judge.sv
hw/score_keeper.sv
hw/rhythm_core.sv
verification/rhythm_core_sva.sv
verification/rhythm_core_tb.sv

//--- verification/rhythm_core_sva.sv
`timescale 1ns/1ps

module rhythm_core_sva import rhythm_pkg::*; (
    input logic        clk_in,
    input logic        rst_in,
    input logic        start,
    input logic        hit,
    input logic        miss,
    input combo_t      combo,
    input game_state_t game_state,
    input game_time_t  curr_time
);

    //////////////////////////////
    // Judge outputs
    //////////////////////////////

    // A slot is either hit or missed, never both
    a_hit_miss_excl: assert property (
        @(posedge clk_in) disable iff (rst_in)
        !(hit && miss)
    ) else $error("hit and miss high in the same cycle");

    a_combo_limit: assert property (
        @(posedge clk_in) disable iff (rst_in)
        combo <= COMBO_MAX
    ) else $error("combo above its ceiling");

    //////////////////////////////
    // Ended game
    //////////////////////////////

    // Ticks stop once the game is won or lost
    a_time_frozen: assert property (
        @(posedge clk_in) disable iff (rst_in)
        ((game_state == ST_WON || game_state == ST_LOST) && !start) |=> $stable(curr_time)
    ) else $error("game time moved after the game ended");

endmodule

bind rhythm_core rhythm_core_sva u_sva (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .start      (start),
    .hit        (hit),
    .miss       (miss),
    .combo      (combo),
    .game_state (game_state),
    .curr_time  (curr_time)
);

//--- verification/rhythm_core_tb.sv
`timescale 1ns/1ps

module rhythm_core_tb import rhythm_pkg::*; ();

    localparam int MAX_BLOCKS  = 8;
    localparam int TICK_CYCLES = 16;
    localparam int MAX_TESTS   = 16;
    localparam int MAX_HANDS   = 64;

    logic        clk_in = 1'b0;
    logic        rst_in;
    logic        start;
    coord_t      hand_x;
    coord_t      hand_y;
    logic        map_wr;
    logic [2:0]  map_slot;
    game_time_t  map_time;
    coord_t      map_x;
    coord_t      map_y;
    swing_dir_t  map_dir;
    game_state_t game_state;
    score_t      score;
    health_t     health;
    combo_t      combo;
    game_time_t  curr_time;
    logic        hit;
    logic        miss;

    // Test table filled from the data file
    string tname      [MAX_TESTS];
    int    treload    [MAX_TESTS];
    int    exp_score  [MAX_TESTS];
    int    exp_health [MAX_TESTS];
    int    exp_combo  [MAX_TESTS];
    int    exp_state  [MAX_TESTS];
    int    blk_time   [MAX_TESTS][MAX_BLOCKS];
    int    blk_x      [MAX_TESTS][MAX_BLOCKS];
    int    blk_y      [MAX_TESTS][MAX_BLOCKS];
    int    blk_dir    [MAX_TESTS][MAX_BLOCKS];
    int    hand_cnt   [MAX_TESTS];
    int    hand_xs    [MAX_TESTS][MAX_HANDS];
    int    hand_ys    [MAX_TESTS][MAX_HANDS];

    int   ntests      = 0;
    int   errors      = 0;
    int   passed      = 0;
    int   failed      = 0;
    int   cycles      = 0;
    int   cycle_limit = 0;
    logic test_bad    = 1'b0;

    // Judge pulses since the run began
    int   hit_total   = 0;
    int   miss_total  = 0;

    rhythm_core #(
        .MAX_BLOCKS  (MAX_BLOCKS),
        .TICK_CYCLES (TICK_CYCLES),
        .HIT_WINDOW  (2),
        .HIT_RADIUS  (64),
        .SWING_MIN   (32)
    ) u_dut (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .start      (start),
        .hand_x     (hand_x),
        .hand_y     (hand_y),
        .map_wr     (map_wr),
        .map_slot   (map_slot),
        .map_time   (map_time),
        .map_x      (map_x),
        .map_y      (map_y),
        .map_dir    (map_dir),
        .game_state (game_state),
        .score      (score),
        .health     (health),
        .combo      (combo),
        .curr_time  (curr_time),
        .hit        (hit),
        .miss       (miss)
    );

    always #50 clk_in = ~clk_in;

    // Watchdog on the total cycle budget
    always @(posedge clk_in) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    always @(posedge clk_in) begin
        if (hit) begin
            hit_total <= hit_total + 1;
        end
        if (miss) begin
            miss_total <= miss_total + 1;
        end
    end

    //////////////////////////////
    // Data file
    //////////////////////////////

    task automatic load_tests(input int fd);
        string tok;
        string skip;
        string nm;
        int    cur;
        int    s;
        int    n;
        int    code;
        cur = -1;
        code = $fscanf(fd, "%s", tok);
        while (code == 1) begin
            if (tok[0] == "#") begin
                code = $fgets(skip, fd);
            end else if (tok == "test") begin
                cur++;
                code = $fscanf(fd, "%s %d %d %d %d %d", nm, treload[cur], exp_score[cur],
                               exp_health[cur], exp_combo[cur], exp_state[cur]);
                tname[cur] = nm;
                hand_cnt[cur] = 0;
                // Slots not listed are written empty
                for (int i = 0; i < MAX_BLOCKS; i++) begin
                    blk_time[cur][i] = 0;
                    blk_x[cur][i]    = 0;
                    blk_y[cur][i]    = 0;
                    blk_dir[cur][i]  = 0;
                end
            end else if (tok == "blk") begin
                code = $fscanf(fd, "%d", s);
                code = $fscanf(fd, "%d %d %d %d", blk_time[cur][s], blk_x[cur][s],
                               blk_y[cur][s], blk_dir[cur][s]);
            end else if (tok == "hand") begin
                code = $fscanf(fd, "%d", n);
                hand_cnt[cur] = n;
                for (int i = 0; i < n; i++) begin
                    code = $fscanf(fd, "%d %d", hand_xs[cur][i], hand_ys[cur][i]);
                end
            end else begin
                $display("Unknown record '%s' in the test file", tok);
                errors++;
            end
            code = $fscanf(fd, "%s", tok);
        end
        ntests = cur + 1;
    endtask

    function automatic int used_slots(input int t);
        int n;
        n = 0;
        for (int s = 0; s < MAX_BLOCKS; s++) begin
            if (blk_dir[t][s] != 0) begin
                n++;
            end
        end
        return n;
    endfunction

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    task automatic apply_reset();
        @(posedge clk_in);
        rst_in <= 1'b1;
        repeat (8) @(posedge clk_in);
        rst_in <= 1'b0;
    endtask

    task automatic write_map(input int t);
        // Live filler blocks first, so empty entries have something to clear
        for (int s = 0; s < MAX_BLOCKS; s++) begin
            @(posedge clk_in);
            map_wr   <= 1'b1;
            map_slot <= 3'(s);
            map_time <= game_time_t'(s);
            map_x    <= coord_t'(s);
            map_y    <= coord_t'(s);
            map_dir  <= DIR_UP;
        end
        for (int s = 0; s < MAX_BLOCKS; s++) begin
            @(posedge clk_in);
            map_wr   <= 1'b1;
            map_slot <= 3'(s);
            map_time <= game_time_t'(blk_time[t][s]);
            map_x    <= coord_t'(blk_x[t][s]);
            map_y    <= coord_t'(blk_y[t][s]);
            map_dir  <= swing_dir_t'(3'(blk_dir[t][s]));
        end
        @(posedge clk_in);
        map_wr <= 1'b0;
    endtask

    // Returns at the first edge that shows game time t or an ended game
    task automatic wait_for_time(input game_time_t t);
        @(posedge clk_in);
        while (curr_time != t && game_state == ST_PLAYING) begin
            @(posedge clk_in);
        end
    endtask

    task automatic play_game(input int t);
        @(posedge clk_in);
        hand_x <= coord_t'(hand_xs[t][0]);
        hand_y <= coord_t'(hand_ys[t][0]);
        @(posedge clk_in);
        start <= 1'b1;
        @(posedge clk_in);
        start <= 1'b0;
        // Sample k goes out once tick k-1 has begun
        for (int k = 1; k < hand_cnt[t]; k++) begin
            wait_for_time(game_time_t'(k - 1));
            if (game_state == ST_PLAYING) begin
                hand_x <= coord_t'(hand_xs[t][k]);
                hand_y <= coord_t'(hand_ys[t][k]);
            end
        end
        wait_for_time(game_time_t'(hand_cnt[t]));
    endtask

    //////////////////////////////
    // Checks
    //////////////////////////////

    task automatic check_score(input string name, input score_t exp, input score_t act);
        if (act !== exp) begin
            $display("ERR %s score expected %0d actual %0d", name, exp, act);
            errors++;
            test_bad = 1'b1;
        end
    endtask

    task automatic check_health(input string name, input health_t exp, input health_t act);
        if (act !== exp) begin
            $display("ERR %s health expected %0d actual %0d", name, exp, act);
            errors++;
            test_bad = 1'b1;
        end
    endtask

    task automatic check_combo(input string name, input combo_t exp, input combo_t act);
        if (act !== exp) begin
            $display("ERR %s combo expected %0d actual %0d", name, exp, act);
            errors++;
            test_bad = 1'b1;
        end
    endtask

    task automatic check_state(input string name, input game_state_t exp,
                               input game_state_t act);
        if (act !== exp) begin
            $display("ERR %s state expected %s actual %s", name, exp.name(), act.name());
            errors++;
            test_bad = 1'b1;
        end
    endtask

    task automatic check_time(input string name, input game_time_t exp,
                              input game_time_t act);
        if (act !== exp) begin
            $display("ERR %s time expected %0d actual %0d", name, exp, act);
            errors++;
            test_bad = 1'b1;
        end
    endtask

    task automatic check_count(input string name, input string what, input int exp,
                               input int act);
        if (act != exp) begin
            $display("ERR %s %s expected %0d actual %0d", name, what, exp, act);
            errors++;
            test_bad = 1'b1;
        end
    endtask

    task automatic run_tests();
        int         map_src;
        int         hit_base;
        int         miss_base;
        int         exp_misses;
        game_time_t exp_time;
        map_src = 0;
        for (int t = 0; t < ntests; t++) begin
            // A new beatmap needs idle, which only reset gives after a game
            if (treload[t] != 0) begin
                apply_reset();
                write_map(t);
                map_src = t;
            end
            hit_base  = hit_total;
            miss_base = miss_total;
            play_game(t);
            test_bad = 1'b0;
            check_score(tname[t], score_t'(exp_score[t]), score);
            check_health(tname[t], health_t'(exp_health[t]), health);
            check_combo(tname[t], combo_t'(exp_combo[t]), combo);
            check_state(tname[t], game_state_t'(2'(exp_state[t])), game_state);
            // Each miss costs one unit of health
            exp_misses = int'(HEALTH_START) - exp_health[t];
            check_count(tname[t], "misses", exp_misses, miss_total - miss_base);
            // Hits follow from the final state where it fixes them
            if (exp_state[t] == int'(ST_WON)) begin
                check_count(tname[t], "hits", used_slots(map_src) - exp_misses,
                            hit_total - hit_base);
            end else if (exp_score[t] == 0) begin
                check_count(tname[t], "hits", 0, hit_total - hit_base);
            end
            // The hand list runs up to the tick that ends the game
            if (exp_state[t] == int'(ST_PLAYING)) begin
                exp_time = game_time_t'(hand_cnt[t]);
            end else begin
                exp_time = game_time_t'(hand_cnt[t] - 1);
            end
            check_time(tname[t], exp_time, curr_time);
            if (test_bad) begin
                failed++;
                $display("FAIL %s", tname[t]);
            end else begin
                passed++;
                $display("ok   %s", tname[t]);
            end
        end
    endtask

    initial begin
        int fd;
        rst_in   = 1'b1;
        start    = 1'b0;
        hand_x   = '0;
        hand_y   = '0;
        map_wr   = 1'b0;
        map_slot = '0;
        map_time = '0;
        map_x    = '0;
        map_y    = '0;
        map_dir  = DIR_NONE;
        fd = $fopen("verification/rhythm_tests.dat", "r");
        if (fd == 0) begin
            $display("Cannot open verification/rhythm_tests.dat");
            $display("*** TEST FAILED ***");
            $finish;
        end else begin
            load_tests(fd);
            $fclose(fd);
            // Every tick listed plus reset, map writes and start per test
            cycle_limit = 100;
            for (int t = 0; t < ntests; t++) begin
                cycle_limit += (hand_cnt[t] + 2) * TICK_CYCLES + 40;
            end
            run_tests();
            $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
                     ntests, passed, failed, errors);
            if (errors == 0 && failed == 0 && ntests > 0) begin
                $display("*** TEST PASSED ***");
            end else begin
                $display("*** TEST FAILED ***");
            end
            $finish;
        end
    end

endmodule

//--- verification/rhythm_tests.dat
# test <name> <reload 1 resets and writes the map> <score> <health> <combo> <state>
# blk <slot> <time> <x> <y> <dir 0 none 1 up 2 down 3 left 4 right>, state 2 won 3 lost
# hand <count> then x y pairs, first pair at start, then one per tick
test all_hits 1 18 4 4 2
blk 0 3 600 500 4
blk 1 5 500 500 3
blk 2 7 600 500 4
blk 3 9 500 500 3
blk 4 11 600 500 4
blk 5 13 500 500 3
hand 14 500 500 500 500 500 500 600 500 600 500 500 500 500 500
        600 500 600 500 500 500 500 500 600 500 600 500 500 500
test lose_all 0 0 0 0 3
hand 13 500 500 500 500 500 500 500 500 500 500 500 500 500 500
        500 500 500 500 500 500 500 500 500 500
test replay 0 18 4 4 2
hand 14 500 500 500 500 500 500 600 500 600 500 500 500 500 500
        600 500 600 500 500 500 500 500 600 500 600 500 500 500
test wrong_dir_radius 1 2 2 0 2
blk 0 3 600 500 4
blk 1 5 500 500 2
blk 2 7 800 500 4
blk 3 9 500 500 3
hand 11 500 500 500 500 500 500 600 500 600 500 500 500
        500 500 600 500 600 500 500 500 500 500
test timing_window 1 1 3 0 2
blk 0 3 600 500 4
blk 1 8 500 500 3
hand 12 500 500 500 500 500 500 500 500 500 500 600 500
        600 500 600 500 600 500 600 500 600 500 500 500
test small_moves 1 0 3 0 2
blk 0 3 500 500 4
blk 3 0 0 0 0
hand 7 500 500 500 500 500 500 520 500 540 500 560 500 560 500
